// File: rtl/fetch_cache_pkg.sv
package fetch_cache_pkg;

	// Geometry of each per-port cache.
	localparam int NUM_PORTS = 2;
	localparam int SET_BITS  = 6;
	localparam int NUM_SETS  = 1 << SET_BITS;
	localparam int TAG_BITS  = 32 - SET_BITS - 2;
	localparam int PORT_BITS = 1;

	typedef logic [31:0]          addr_t;
	typedef logic [31:0]          word_t;
	typedef logic [SET_BITS-1:0]  set_t;
	typedef logic [TAG_BITS-1:0]  tag_t;
	typedef logic [PORT_BITS-1:0] port_t;

	// One cache line holding a single instruction word.
	typedef struct packed {
		logic  valid;
		tag_t  tag;
		word_t data;
	} cache_entry_t;

	// Word-aligned refill request from a cache port.
	typedef struct packed {
		logic  valid;
		addr_t addr;
	} refill_req_t;

	// Refill answer with a single-cycle done strobe.
	typedef struct packed {
		logic  done;
		word_t data;
	} refill_rsp_t;

	typedef enum logic [1:0] {CLEAR, LOOKUP, REFILL} icache_state_e;

	typedef enum logic [1:0] {IDLE, ADDR, DATA} arb_state_e;

endpackage

// File: rtl/icache_tag_ram.sv
`timescale 1ns/1ps

module icache_tag_ram (
	input  logic                          i_clock,
	input  fetch_cache_pkg::set_t         i_rd_set,
	output fetch_cache_pkg::cache_entry_t o_rd_entry,
	input  logic                          i_wr_en,
	input  fetch_cache_pkg::set_t         i_wr_set,
	input  fetch_cache_pkg::cache_entry_t i_wr_entry
);

	fetch_cache_pkg::cache_entry_t mem [fetch_cache_pkg::NUM_SETS];

	always_ff @(posedge i_clock) begin
		if (i_wr_en) begin
			mem[i_wr_set] <= i_wr_entry;
		end
	end

	// A colliding write is forwarded so a refilled line is seen by the next read.
	always_ff @(posedge i_clock) begin
		if (i_wr_en && (i_wr_set == i_rd_set)) begin
			o_rd_entry <= i_wr_entry;
		end else begin
			o_rd_entry <= mem[i_rd_set];
		end
	end

endmodule

// File: rtl/icache_port.sv
`timescale 1ns/1ps

module icache_port (
	input  logic                         i_clock,
	input  logic                         i_reset,
	input  fetch_cache_pkg::addr_t       i_pc,
	output fetch_cache_pkg::word_t       o_rdata,
	output logic                         o_ready,
	output fetch_cache_pkg::refill_req_t o_refill_req,
	input  fetch_cache_pkg::refill_rsp_t i_refill_rsp
);

	localparam int SET_LSB = 2;
	localparam int TAG_LSB = fetch_cache_pkg::SET_BITS + 2;

	fetch_cache_pkg::icache_state_e state;
	fetch_cache_pkg::set_t          clear_set;

	fetch_cache_pkg::set_t         pc_set;
	fetch_cache_pkg::tag_t         pc_tag;
	fetch_cache_pkg::set_t         rd_set;
	fetch_cache_pkg::set_t         set_r;
	logic                          rd_live;
	fetch_cache_pkg::cache_entry_t rd_entry;

	logic                          wr_en;
	fetch_cache_pkg::set_t         wr_set;
	fetch_cache_pkg::cache_entry_t wr_entry;

	logic                          hit;
	logic                          miss;
	logic                          fill_q;
	fetch_cache_pkg::word_t        fill_data_q;
	fetch_cache_pkg::addr_t        req_addr_q;

	assign pc_set = i_pc[SET_LSB +: fetch_cache_pkg::SET_BITS];
	assign pc_tag = i_pc[TAG_LSB +: fetch_cache_pkg::TAG_BITS];

	icache_tag_ram u_tag_ram (
		.i_clock    (i_clock),
		.i_rd_set   (rd_set),
		.o_rd_entry (rd_entry),
		.i_wr_en    (wr_en),
		.i_wr_set   (wr_set),
		.i_wr_entry (wr_entry)
	);

	// The line is only trusted when it was read for this set during lookup.
	always_comb begin
		hit  = 1'b0;
		miss = 1'b0;
		if (state == fetch_cache_pkg::LOOKUP && rd_live && set_r == pc_set) begin
			if (rd_entry.valid && rd_entry.tag == pc_tag) begin
				hit = 1'b1;
			end else begin
				miss = 1'b1;
			end
		end
	end

	// Read ahead on a hit so a sequential PC hits again next cycle.
	assign rd_set  = hit ? pc_set + 1'b1 : pc_set;
	assign o_ready = hit;
	assign o_rdata = rd_entry.data;

	always_comb begin
		if (state == fetch_cache_pkg::CLEAR) begin
			wr_en    = 1'b1;
			wr_set   = clear_set;
			wr_entry = '0;
		end else begin
			wr_en          = fill_q;
			wr_set         = req_addr_q[SET_LSB +: fetch_cache_pkg::SET_BITS];
			wr_entry.valid = 1'b1;
			wr_entry.tag   = req_addr_q[TAG_LSB +: fetch_cache_pkg::TAG_BITS];
			wr_entry.data  = fill_data_q;
		end
	end

	assign o_refill_req.valid = (state == fetch_cache_pkg::REFILL);
	assign o_refill_req.addr  = req_addr_q;

	always_ff @(posedge i_clock) begin
		set_r <= rd_set;
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state     <= fetch_cache_pkg::CLEAR;
			clear_set <= '0;
			rd_live   <= 1'b0;
			fill_q    <= 1'b0;
		end else begin
			rd_live <= (state == fetch_cache_pkg::LOOKUP);
			fill_q  <= 1'b0;
			case (state)
				fetch_cache_pkg::CLEAR: begin
					clear_set <= clear_set + 1'b1;
					if (clear_set == fetch_cache_pkg::set_t'(fetch_cache_pkg::NUM_SETS - 1)) begin
						state <= fetch_cache_pkg::LOOKUP;
					end
				end
				fetch_cache_pkg::LOOKUP: begin
					if (miss) begin
						state <= fetch_cache_pkg::REFILL;
					end
				end
				fetch_cache_pkg::REFILL: begin
					// Line is written next cycle.
					if (i_refill_rsp.done) begin
						fill_q <= 1'b1;
						state  <= fetch_cache_pkg::LOOKUP;
					end
				end
				default: begin
					state <= fetch_cache_pkg::CLEAR;
				end
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (miss) begin
			req_addr_q <= {i_pc[31:2], 2'b00};
		end
		if (i_refill_rsp.done) begin
			fill_data_q <= i_refill_rsp.data;
		end
	end

	a_no_ready_in_clear: assert property (@(posedge i_clock) disable iff (i_reset)
		state == fetch_cache_pkg::CLEAR |-> !o_ready);

	a_req_stable: assert property (@(posedge i_clock) disable iff (i_reset)
		o_refill_req.valid && !i_refill_rsp.done
		|=> o_refill_req.valid && $stable(o_refill_req.addr));

	a_done_needs_req: assert property (@(posedge i_clock) disable iff (i_reset)
		i_refill_rsp.done |-> o_refill_req.valid);

endmodule

// File: rtl/refill_arbiter.sv
`timescale 1ns/1ps

module refill_arbiter (
	input  logic                                                      i_clock,
	input  logic                                                      i_reset,
	input  fetch_cache_pkg::refill_req_t [fetch_cache_pkg::NUM_PORTS-1:0] i_refill_req,
	output fetch_cache_pkg::refill_rsp_t [fetch_cache_pkg::NUM_PORTS-1:0] o_refill_rsp,
	output logic                                                      o_axi_arvalid,
	input  logic                                                      i_axi_arready,
	output fetch_cache_pkg::addr_t                                    o_axi_araddr,
	input  logic                                                      i_axi_rvalid,
	output logic                                                      o_axi_rready,
	input  fetch_cache_pkg::word_t                                    i_axi_rdata
);

	fetch_cache_pkg::arb_state_e state;
	fetch_cache_pkg::port_t      rr_ptr;
	fetch_cache_pkg::port_t      grant_q;
	fetch_cache_pkg::port_t      pick;
	fetch_cache_pkg::port_t      cand;
	logic                        pick_valid;
	fetch_cache_pkg::addr_t      araddr_q;
	fetch_cache_pkg::word_t      rdata_q;
	logic                        done_q;
	logic [fetch_cache_pkg::NUM_PORTS-1:0] done_vec;

	// Search starts at the port after the last grant.
	always_comb begin
		pick_valid = 1'b0;
		pick       = rr_ptr;
		cand       = rr_ptr;
		for (int i = 1; i <= fetch_cache_pkg::NUM_PORTS; i++) begin
			cand = fetch_cache_pkg::port_t'((int'(rr_ptr) + i) % fetch_cache_pkg::NUM_PORTS);
			if (!pick_valid && i_refill_req[cand].valid) begin
				pick_valid = 1'b1;
				pick       = cand;
			end
		end
	end

	assign o_axi_arvalid = (state == fetch_cache_pkg::ADDR);
	assign o_axi_araddr  = araddr_q;
	assign o_axi_rready  = (state == fetch_cache_pkg::DATA);

	always_comb begin
		for (int p = 0; p < fetch_cache_pkg::NUM_PORTS; p++) begin
			done_vec[p]          = done_q && (grant_q == fetch_cache_pkg::port_t'(p));
			o_refill_rsp[p].done = done_vec[p];
			o_refill_rsp[p].data = rdata_q;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state  <= fetch_cache_pkg::IDLE;
			rr_ptr <= fetch_cache_pkg::port_t'(fetch_cache_pkg::NUM_PORTS - 1);
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state)
				fetch_cache_pkg::IDLE: begin
					// The port just served still shows its request while done is out.
					if (pick_valid && !done_q) begin
						rr_ptr <= pick;
						state  <= fetch_cache_pkg::ADDR;
					end
				end
				fetch_cache_pkg::ADDR: begin
					if (i_axi_arready) begin
						state <= fetch_cache_pkg::DATA;
					end
				end
				fetch_cache_pkg::DATA: begin
					if (i_axi_rvalid) begin
						done_q <= 1'b1;
						state  <= fetch_cache_pkg::IDLE;
					end
				end
				default: begin
					state <= fetch_cache_pkg::IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (state == fetch_cache_pkg::IDLE && pick_valid && !done_q) begin
			grant_q  <= pick;
			araddr_q <= i_refill_req[pick].addr;
		end
		if (state == fetch_cache_pkg::DATA && i_axi_rvalid) begin
			rdata_q <= i_axi_rdata;
		end
	end

	a_ar_stable: assert property (@(posedge i_clock) disable iff (i_reset)
		o_axi_arvalid && !i_axi_arready |=> o_axi_arvalid && $stable(o_axi_araddr));

	// The data phase lies between an AR handshake and the following R handshake.
	a_rready_in_data: assert property (@(posedge i_clock) disable iff (i_reset)
		o_axi_rready |-> $past(o_axi_arvalid && i_axi_arready)
			|| $past(o_axi_rready && !i_axi_rvalid));

	a_done_onehot: assert property (@(posedge i_clock) disable iff (i_reset)
		$onehot0(done_vec));

endmodule

// File: rtl/fetch_cache_top.sv
`timescale 1ns/1ps

module fetch_cache_top (
	input  logic                                                 i_clock,
	input  logic                                                 i_reset,
	input  fetch_cache_pkg::addr_t [fetch_cache_pkg::NUM_PORTS-1:0] i_pc,
	output fetch_cache_pkg::word_t [fetch_cache_pkg::NUM_PORTS-1:0] o_rdata,
	output logic [fetch_cache_pkg::NUM_PORTS-1:0]                o_ready,
	output logic                                                 o_axi_arvalid,
	input  logic                                                 i_axi_arready,
	output fetch_cache_pkg::addr_t                               o_axi_araddr,
	input  logic                                                 i_axi_rvalid,
	output logic                                                 o_axi_rready,
	input  fetch_cache_pkg::word_t                               i_axi_rdata
);

	fetch_cache_pkg::refill_req_t [fetch_cache_pkg::NUM_PORTS-1:0] refill_req;
	fetch_cache_pkg::refill_rsp_t [fetch_cache_pkg::NUM_PORTS-1:0] refill_rsp;

	// One private cache per fetch port.
	for (genvar p = 0; p < fetch_cache_pkg::NUM_PORTS; p++) begin : g_port
		icache_port u_icache_port (
			.i_clock      (i_clock),
			.i_reset      (i_reset),
			.i_pc         (i_pc[p]),
			.o_rdata      (o_rdata[p]),
			.o_ready      (o_ready[p]),
			.o_refill_req (refill_req[p]),
			.i_refill_rsp (refill_rsp[p])
		);
	end

	// All misses share one read master.
	refill_arbiter u_refill_arbiter (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_refill_req  (refill_req),
		.o_refill_rsp  (refill_rsp),
		.o_axi_arvalid (o_axi_arvalid),
		.i_axi_arready (i_axi_arready),
		.o_axi_araddr  (o_axi_araddr),
		.i_axi_rvalid  (i_axi_rvalid),
		.o_axi_rready  (o_axi_rready),
		.i_axi_rdata   (i_axi_rdata)
	);

endmodule

// File: sim/axil_rom_model.sv
`timescale 1ns/1ps

module axil_rom_model #(
	parameter int SEED = 75
) (
	input  logic                   i_clock,
	input  logic                   i_reset,
	input  logic                   i_arvalid,
	output logic                   o_arready,
	input  fetch_cache_pkg::addr_t i_araddr,
	output logic                   o_rvalid,
	input  logic                   i_rready,
	output fetch_cache_pkg::word_t o_rdata
);

	int                     seed;
	int                     wait_left;
	logic                   busy;
	fetch_cache_pkg::addr_t addr_q;

	initial begin
		seed      = SEED;
		wait_left = 0;
		busy      = 1'b0;
		addr_q    = '0;
		o_arready = 1'b0;
		o_rvalid  = 1'b0;
		o_rdata   = '0;
	end

	// Outputs change on the falling edge and are sampled on the rising edge.
	always @(negedge i_clock) begin
		if (i_reset) begin
			o_arready = 1'b0;
			o_rvalid  = 1'b0;
			busy      = 1'b0;
			wait_left = 0;
		end else if (o_arready) begin
			// The address was taken at the last rising edge.
			o_arready = 1'b0;
			busy      = 1'b1;
			wait_left = $random(seed) & 3;
		end else if (o_rvalid) begin
			o_rvalid  = 1'b0;
			busy      = 1'b0;
			wait_left = $random(seed) & 3;
		end else if (busy) begin
			if (wait_left == 0 && i_rready) begin
				o_rvalid = 1'b1;
				o_rdata  = ~addr_q;
			end else if (wait_left > 0) begin
				wait_left = wait_left - 1;
			end
		end else if (i_arvalid) begin
			if (wait_left == 0) begin
				o_arready = 1'b1;
				addr_q    = i_araddr;
			end else begin
				wait_left = wait_left - 1;
			end
		end
	end

endmodule

// File: sim/tb_fetch_cache.sv
`timescale 1ns/1ps

module tb_fetch_cache;

	localparam int NUM_PORTS = fetch_cache_pkg::NUM_PORTS;
	localparam int NUM_SETS  = fetch_cache_pkg::NUM_SETS;
	// Twice the roughly 3000 cycles that the phases take.
	localparam int TIMEOUT_CYCLES    = 6000;
	localparam int STALL_LIMIT       = 200;
	localparam int LOOP_WORDS        = 16;
	localparam int CONFLICT_SWITCHES = 8;
	localparam int JUMP_RUNS         = 20;
	localparam fetch_cache_pkg::addr_t LOOP_BASE0 = 32'h0000_1000;
	localparam fetch_cache_pkg::addr_t LOOP_BASE1 = 32'h0000_2040;
	localparam fetch_cache_pkg::addr_t CONFLICT_A = 32'h0000_3000;
	localparam fetch_cache_pkg::addr_t CONFLICT_B = 32'h0000_3100;
	localparam fetch_cache_pkg::addr_t JUMP_BASE  = 32'h0001_0000;

	logic                                    clock;
	logic                                    reset;
	fetch_cache_pkg::addr_t [NUM_PORTS-1:0]  pc;
	fetch_cache_pkg::word_t [NUM_PORTS-1:0]  rdata;
	logic [NUM_PORTS-1:0]                    ready;
	logic [NUM_PORTS-1:0]                    ready_seen;
	logic [NUM_PORTS-1:0]                    seq_run;
	logic                                    axi_arvalid;
	logic                                    axi_arready;
	fetch_cache_pkg::addr_t                  axi_araddr;
	logic                                    axi_rvalid;
	logic                                    axi_rready;
	fetch_cache_pkg::word_t                  axi_rdata;
	int                                      phase;
	int                                      seed;
	int                                      value_errors;
	int                                      other_errors;
	int                                      since_reset;
	int                                      ar_count;
	int                                      ar_base;
	int                                      cycle_count;
	fetch_cache_pkg::addr_t                  jump_pc [NUM_PORTS][JUMP_RUNS];
	int                                      jump_len [NUM_PORTS][JUMP_RUNS];

	fetch_cache_top u_dut (
		.i_clock       (clock),
		.i_reset       (reset),
		.i_pc          (pc),
		.o_rdata       (rdata),
		.o_ready       (ready),
		.o_axi_arvalid (axi_arvalid),
		.i_axi_arready (axi_arready),
		.o_axi_araddr  (axi_araddr),
		.i_axi_rvalid  (axi_rvalid),
		.o_axi_rready  (axi_rready),
		.i_axi_rdata   (axi_rdata)
	);

	axil_rom_model u_rom (
		.i_clock   (clock),
		.i_reset   (reset),
		.i_arvalid (axi_arvalid),
		.o_arready (axi_arready),
		.i_araddr  (axi_araddr),
		.o_rvalid  (axi_rvalid),
		.i_rready  (axi_rready),
		.o_rdata   (axi_rdata)
	);

	function automatic fetch_cache_pkg::addr_t word_align(input fetch_cache_pkg::addr_t addr);
		return {addr[31:2], 2'b00};
	endfunction

	// The memory answers with the inverted word address.
	function automatic fetch_cache_pkg::word_t rom_word(input fetch_cache_pkg::addr_t addr);
		return ~word_align(addr);
	endfunction

	function automatic logic pc_requested(input fetch_cache_pkg::addr_t addr,
			input fetch_cache_pkg::addr_t [NUM_PORTS-1:0] pcs);
		logic found;
		found = 1'b0;
		for (int p = 0; p < NUM_PORTS; p++) begin
			if (addr == word_align(pcs[p])) begin
				found = 1'b1;
			end
		end
		return found;
	endfunction

	// Fetch len sequential words from start and advance after each o_ready.
	task automatic fetch_run(input int p, input fetch_cache_pkg::addr_t start, input int len);
		int count;
		count      = 0;
		pc[p]      = start;
		seq_run[p] = 1'b0;
		while (count < len) begin
			@(negedge clock);
			if (ready_seen[p]) begin
				count++;
				if (count < len) begin
					pc[p]      = pc[p] + 32'd4;
					seq_run[p] = 1'b1;
				end else begin
					seq_run[p] = 1'b0;
				end
			end
		end
	endtask

	task automatic draw_jumps();
		for (int p = 0; p < NUM_PORTS; p++) begin
			for (int k = 0; k < JUMP_RUNS; k++) begin
				jump_pc[p][k]  = JUMP_BASE + (fetch_cache_pkg::addr_t'($random(seed)) & 32'hffc);
				jump_len[p][k] = 1 + (($random(seed) & 32'h7fff_ffff) % 8);
			end
		end
	endtask

	task automatic jump_port(input int p);
		for (int k = 0; k < JUMP_RUNS; k++) begin
			fetch_run(p, jump_pc[p][k], jump_len[p][k]);
		end
	endtask

	task automatic print_counts();
		$display("Checks done: %0d value errors, %0d other errors", value_errors, other_errors);
	endtask

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	always @(posedge clock) begin
		ready_seen <= ready;
		if (reset) begin
			since_reset <= 0;
			ar_count    <= 0;
		end else begin
			if (since_reset < NUM_SETS) begin
				since_reset <= since_reset + 1;
			end
			if (axi_arvalid && axi_arready) begin
				ar_count <= ar_count + 1;
			end
		end
	end

	for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port_check
		int stall;

		always @(posedge clock) begin
			if (reset || ready[p] || since_reset < NUM_SETS) begin
				stall <= 0;
			end else begin
				stall <= stall + 1;
			end
		end

		a_data: assert property (@(posedge clock) disable iff (reset)
			ready[p] |-> rdata[p] == rom_word(pc[p]))
			else begin
				value_errors++;
				$display("ERROR at %0t: o_rdata[%0d] expected %h actual %h", $time, p,
					rom_word($sampled(pc[p])), $sampled(rdata[p]));
			end

		a_seq_hit: assert property (@(posedge clock) disable iff (reset)
			phase == 2 && seq_run[p] |-> ready[p])
			else begin
				value_errors++;
				$display("ERROR at %0t: o_ready[%0d] expected 1 actual 0", $time, p);
			end

		a_progress: assert property (@(posedge clock) disable iff (reset)
			stall < STALL_LIMIT)
			else begin
				other_errors++;
				$display("ERROR at %0t: port %0d got no o_ready for %0d cycles", $time, p,
					STALL_LIMIT);
			end
	end

	a_clear: assert property (@(posedge clock) disable iff (reset)
		since_reset < NUM_SETS |-> ready == '0 && !axi_arvalid)
		else begin
			other_errors++;
			$display("ERROR at %0t: fetch or bus activity during the clear sequence", $time);
		end

	a_ar_stable: assert property (@(posedge clock) disable iff (reset)
		axi_arvalid && !axi_arready |=> axi_arvalid && $stable(axi_araddr))
		else begin
			other_errors++;
			$display("ERROR at %0t: AR request dropped or changed before arready", $time);
		end

	// The R channel opens after each AR handshake and closes on the R handshake.
	a_rready: assert property (@(posedge clock) disable iff (reset)
		axi_rready == ($past(axi_arvalid && axi_arready) || $past(axi_rready && !axi_rvalid)))
		else begin
			value_errors++;
			$display("ERROR at %0t: o_axi_rready expected %b actual %b", $time,
				!$sampled(axi_rready), $sampled(axi_rready));
		end

	a_ar_addr: assert property (@(posedge clock) disable iff (reset)
		axi_arvalid |-> pc_requested(axi_araddr, pc))
		else begin
			other_errors++;
			$display("ERROR at %0t: araddr %h matches no fetch PC", $time, $sampled(axi_araddr));
		end

	a_no_refetch: assert property (@(posedge clock) disable iff (reset)
		phase == 2 |-> !(axi_arvalid && axi_arready))
		else begin
			other_errors++;
			$display("ERROR at %0t: bus read of %h during the second pass", $time,
				$sampled(axi_araddr));
		end

	a_conflict: assert property (@(posedge clock) disable iff (reset)
		phase == 3 && ready[0] |-> ar_count - ar_base == 1)
		else begin
			value_errors++;
			$display("ERROR at %0t: AR handshakes per switch expected 1 actual %0d", $time,
				$sampled(ar_count) - $sampled(ar_base));
		end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("ERROR at %0t: run did not finish within %0d cycles", $time, TIMEOUT_CYCLES);
		print_counts();
		$display("Something failed");
		$finish;
	end

	initial begin
		seed         = 75;
		reset        = 1'b1;
		pc           = '0;
		seq_run      = '0;
		phase        = 0;
		ar_base      = 0;
		value_errors = 0;
		other_errors = 0;
		draw_jumps();
		repeat (8) @(negedge clock);
		reset = 1'b0;

		phase = 1;
		fork
			fetch_run(0, LOOP_BASE0, LOOP_WORDS);
			fetch_run(1, LOOP_BASE1, LOOP_WORDS);
		join

		phase = 2;
		fork
			fetch_run(0, LOOP_BASE0, LOOP_WORDS);
			fetch_run(1, LOOP_BASE1, LOOP_WORDS);
		join

		// Both addresses share set 0 with different tags.
		phase = 3;
		for (int k = 0; k < CONFLICT_SWITCHES; k++) begin
			ar_base = ar_count;
			fetch_run(0, (k % 2 == 0) ? CONFLICT_A : CONFLICT_B, 1);
		end

		phase = 4;
		fork
			jump_port(0);
			jump_port(1);
		join

		repeat (4) @(negedge clock);
		print_counts();
		if (value_errors == 0 && other_errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// File: fetch_cache.f
rtl/fetch_cache_pkg.sv
rtl/icache_tag_ram.sv
rtl/icache_port.sv
rtl/refill_arbiter.sv
rtl/fetch_cache_top.sv
sim/axil_rom_model.sv
sim/tb_fetch_cache.sv

// File: Bender.yml
package:
  name: fetch_cache

sources:
  - files:
      - rtl/fetch_cache_pkg.sv
      - rtl/icache_tag_ram.sv
      - rtl/icache_port.sv
      - rtl/refill_arbiter.sv
      - rtl/fetch_cache_top.sv
  - target: simulation
    files:
      - sim/axil_rom_model.sv
      - sim/tb_fetch_cache.sv
